// ==== design/rsa_pkg.sv ====
package rsa_pkg;

    // operand and byte geometry
    localparam int rsa_w     = 256;
    localparam int byte_w    = 8;
    localparam int key_bytes = 32;
    localparam int out_bytes = 31;
    localparam int idx_w     = 8;

    // avalon bus shape
    localparam int addr_w = 5;
    localparam int data_w = 32;

    // serial port register map in word addresses
    localparam logic [addr_w-1:0] rx_base     = 5'd0;
    localparam logic [addr_w-1:0] tx_base     = 5'd4;
    localparam logic [addr_w-1:0] status_base = 5'd8;
    localparam int                tx_ok_bit   = 6;
    localparam int                rx_ok_bit   = 7;

    // wrapper byte counter runs over n then d then a
    localparam int cnt_w   = 7;
    localparam int a_first = 2 * key_bytes;
    localparam int rx_last = 3 * key_bytes - 1;
    localparam int tx_last = out_bytes - 1;

    typedef struct packed {
        logic [rsa_w-1:0] n;
        logic [rsa_w-1:0] d;
        logic [rsa_w-1:0] a;
    } rsa_req_t;

    typedef struct packed {
        logic [rsa_w-1:0] x;
        logic [rsa_w-1:0] y;
        logic [rsa_w-1:0] n;
    } mont_req_t;

    typedef enum logic [2:0] {
        query_rx,
        read_byte,
        wait_calc,
        query_tx,
        send_byte
    } avm_state_e;

    typedef enum logic [1:0] {
        idle,
        prep,
        loop,
        finish
    } core_state_e;

endpackage

// ==== design/rsa_modprod.sv ====
module rsa_modprod
    import rsa_pkg::*;
(
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  logic [rsa_w-1:0] a,
    input  logic [rsa_w-1:0] n,
    output logic [rsa_w-1:0] result,
    output logic             done
);

    logic             busy;
    logic [idx_w-1:0] cnt;
    logic [rsa_w-1:0] acc;
    // doubled value needs one extra bit before the reduction
    logic [rsa_w:0]   dbl;
    logic [rsa_w:0]   red;

    assign dbl = {acc, 1'b0};
    assign red = (dbl >= {1'b0, n}) ? dbl - {1'b0, n} : dbl;

    // acc stops moving after done, so the result holds until the next start
    assign result = acc;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == '1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // a is below n, so one subtract per doubling keeps acc reduced
    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= a;
        end else if (busy) begin
            acc <= red[rsa_w-1:0];
        end
    end

    a_no_restart : assert property (
        @(posedge avm_clk) disable iff (avm_rst) start |-> !busy
    );

endmodule

// ==== design/rsa_mont.sv ====
module rsa_mont
    import rsa_pkg::*;
(
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  mont_req_t        req,
    output logic [rsa_w-1:0] result,
    output logic             done
);

    logic             busy;
    logic             fix;
    logic [idx_w-1:0] cnt;
    // running sum stays below 2n
    logic [rsa_w:0]   acc;
    logic [rsa_w:0]   diff;
    logic [rsa_w-1:0] x_r;
    logic [rsa_w-1:0] y_r;
    logic [rsa_w-1:0] n_r;

    // one radix-2 step adds x on a set bit, makes the sum even with n and halves it
    function automatic logic [rsa_w:0] mont_step(
        input logic [rsa_w:0]   sum_in,
        input logic [rsa_w-1:0] x,
        input logic [rsa_w-1:0] n,
        input logic             y_bit
    );
        logic [rsa_w+1:0] sum;
        sum = {1'b0, sum_in};
        if (y_bit) begin
            sum = sum + x;
        end
        if (sum[0]) begin
            sum = sum + n;
        end
        return sum[rsa_w+1:1];
    endfunction

    assign diff = acc - {1'b0, n_r};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            fix  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= idx_w'(1);
            end else if (fix) begin
                fix  <= 1'b0;
                busy <= 1'b0;
                done <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == '1) begin
                    fix <= 1'b1;
                end
            end
        end
    end

    // bit 0 of y is taken straight from the request on the start cycle
    always_ff @(posedge avm_clk) begin
        if (start) begin
            x_r <= req.x;
            n_r <= req.n;
            y_r <= req.y >> 1;
            acc <= mont_step('0, req.x, req.n, req.y[0]);
        end else if (fix) begin
            result <= (acc >= {1'b0, n_r}) ? diff[rsa_w-1:0] : acc[rsa_w-1:0];
        end else if (busy) begin
            acc <= mont_step(acc, x_r, n_r, y_r[0]);
            y_r <= y_r >> 1;
        end
    end

    a_no_restart : assert property (
        @(posedge avm_clk) disable iff (avm_rst) start |-> !busy
    );

endmodule

// ==== design/rsa_core.sv ====
module rsa_core
    import rsa_pkg::*;
(
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  rsa_req_t         req,
    output logic [rsa_w-1:0] result,
    output logic             finished
);

    core_state_e      state;
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] idx_nxt;
    // m stays in the normal domain while t lives in the montgomery domain
    logic [rsa_w-1:0] m;
    logic [rsa_w-1:0] t;
    logic             pre_start;
    logic             pre_done;
    logic [rsa_w-1:0] pre_result;
    logic             sq_start;
    logic             sq_done;
    logic [rsa_w-1:0] sq_result;
    logic             mul_start;
    logic             mul_done;
    logic [rsa_w-1:0] mul_result;
    mont_req_t        sq_req;
    mont_req_t        mul_req;
    logic             step_done;

    assign pre_start = start && (state == idle);
    assign idx_nxt   = idx + 1'b1;
    assign sq_req    = '{x: t, y: t, n: req.n};
    assign mul_req   = '{x: m, y: t, n: req.n};
    assign step_done = sq_done && (mul_done || !req.d[idx]);
    assign finished  = (state == finish);
    assign result    = m;

    rsa_modprod i_modprod (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (pre_start),
        .a       (req.a),
        .n       (req.n),
        .result  (pre_result),
        .done    (pre_done)
    );

    rsa_mont i_mont_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mul_start),
        .req     (mul_req),
        .result  (mul_result),
        .done    (mul_done)
    );

    rsa_mont i_mont_sq (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (sq_start),
        .req     (sq_req),
        .result  (sq_result),
        .done    (sq_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state     <= idle;
            idx       <= '0;
            sq_start  <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            sq_start  <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= prep;
                    end
                end
                prep: begin
                    if (pre_done) begin
                        state     <= loop;
                        idx       <= '0;
                        sq_start  <= 1'b1;
                        mul_start <= req.d[0];
                    end
                end
                loop: begin
                    if (step_done) begin
                        if (idx == idx_w'(rsa_w - 1)) begin
                            state <= finish;
                        end else begin
                            idx       <= idx_nxt;
                            sq_start  <= 1'b1;
                            mul_start <= req.d[idx_nxt];
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == prep && pre_done) begin
            m <= rsa_w'(1);
            t <= pre_result;
        end else if (state == loop && step_done) begin
            t <= sq_result;
            if (req.d[idx]) begin
                m <= mul_result;
            end
        end
    end

    // the wrapper starts a block only while the core is free
    a_start_when_idle : assert property (
        @(posedge avm_clk) disable iff (avm_rst) start |-> state == idle
    );

    // operands are held by the wrapper for the whole exponentiation
    a_req_stable : assert property (
        @(posedge avm_clk) disable iff (avm_rst) state != idle |-> $stable(req)
    );

endmodule

// ==== design/rsa_avm_wrapper.sv ====
module rsa_avm_wrapper
    import rsa_pkg::*;
(
    input  logic              avm_clk,
    input  logic              avm_rst,
    output logic [addr_w-1:0] avm_address,
    output logic              avm_read,
    input  logic [data_w-1:0] avm_readdata,
    output logic              avm_write,
    output logic [data_w-1:0] avm_writedata,
    input  logic              avm_waitrequest,
    output logic              start,
    output rsa_req_t          req,
    input  logic              finished,
    input  logic [rsa_w-1:0]  result
);

    avm_state_e       state;
    logic [cnt_w-1:0] byte_cnt;
    // result being sent is rotated one byte per write
    logic [rsa_w-1:0] dec;
    logic [byte_w-1:0] rx_byte;
    logic             xfer_done;

    assign rx_byte   = avm_readdata[byte_w-1:0];
    assign xfer_done = !avm_waitrequest;

    // the top result byte is never sent
    assign avm_writedata = {{(data_w - byte_w){1'b0}}, dec[rsa_w-byte_w-1 -: byte_w]};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= query_rx;
            byte_cnt    <= '0;
            start       <= 1'b0;
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
            avm_address <= status_base;
        end else begin
            start <= 1'b0;
            case (state)
                query_rx: begin
                    // a poll without rx ready just issues the next poll
                    if (xfer_done && avm_readdata[rx_ok_bit]) begin
                        avm_address <= rx_base;
                        state       <= read_byte;
                    end
                end
                read_byte: begin
                    if (xfer_done) begin
                        avm_address <= status_base;
                        if (byte_cnt == cnt_w'(rx_last)) begin
                            avm_read <= 1'b0;
                            start    <= 1'b1;
                            byte_cnt <= '0;
                            state    <= wait_calc;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= query_rx;
                        end
                    end
                end
                wait_calc: begin
                    if (finished) begin
                        avm_read <= 1'b1;
                        state    <= query_tx;
                    end
                end
                query_tx: begin
                    if (xfer_done && avm_readdata[tx_ok_bit]) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= tx_base;
                        state       <= send_byte;
                    end
                end
                send_byte: begin
                    if (xfer_done) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                        if (byte_cnt == cnt_w'(tx_last)) begin
                            // the key stays loaded and only the next ciphertext is read
                            byte_cnt <= cnt_w'(a_first);
                            state    <= query_rx;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= query_tx;
                        end
                    end
                end
                default: state <= query_rx;
            endcase
        end
    end

    // bytes arrive most significant first
    always_ff @(posedge avm_clk) begin
        if (state == read_byte && xfer_done) begin
            if (byte_cnt < cnt_w'(key_bytes)) begin
                req.n <= {req.n[rsa_w-byte_w-1:0], rx_byte};
            end else if (byte_cnt < cnt_w'(a_first)) begin
                req.d <= {req.d[rsa_w-byte_w-1:0], rx_byte};
            end else begin
                req.a <= {req.a[rsa_w-byte_w-1:0], rx_byte};
            end
        end
        if (state == wait_calc && finished) begin
            dec <= result;
        end else if (state == send_byte && xfer_done) begin
            dec <= {dec[rsa_w-byte_w-1:0], dec[rsa_w-1 -: byte_w]};
        end
    end

    a_no_read_write : assert property (
        @(posedge avm_clk) disable iff (avm_rst) !(avm_read && avm_write)
    );

    a_hold_on_wait : assert property (
        @(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_read) && $stable(avm_write) && $stable(avm_address)
            && $stable(avm_writedata)
    );

    a_write_to_tx : assert property (
        @(posedge avm_clk) disable iff (avm_rst) avm_write |-> avm_address == tx_base
    );

endmodule

// ==== design/rsa_top.sv ====
module rsa_top
    import rsa_pkg::*;
(
    input  logic              avm_clk,
    input  logic              avm_rst,
    output logic [addr_w-1:0] avm_address,
    output logic              avm_read,
    input  logic [data_w-1:0] avm_readdata,
    output logic              avm_write,
    output logic [data_w-1:0] avm_writedata,
    input  logic              avm_waitrequest
);

    logic             start;
    logic             finished;
    rsa_req_t         req;
    logic [rsa_w-1:0] result;

    rsa_avm_wrapper i_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start),
        .req             (req),
        .finished        (finished),
        .result          (result)
    );

    rsa_core i_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start),
        .req      (req),
        .result   (result),
        .finished (finished)
    );

endmodule

// ==== verification/rsa_tb_tests.svh ====
logic [rsa_w-1:0] key_n;
logic [rsa_w-1:0] key_d;
logic [rsa_w-1:0] last_a;

// a^d mod n by square and multiply with 512-bit products
function automatic logic [rsa_w-1:0] mod_exp(
    input logic [rsa_w-1:0] a,
    input logic [rsa_w-1:0] d,
    input logic [rsa_w-1:0] n
);
    logic [2*rsa_w-1:0] r;
    logic [2*rsa_w-1:0] b;
    logic [2*rsa_w-1:0] m;
    m = {{rsa_w{1'b0}}, n};
    r = 1 % m;
    b = {{rsa_w{1'b0}}, a} % m;
    for (int i = 0; i < rsa_w; i++) begin
        if (d[i]) begin
            r = (r * b) % m;
        end
        b = (b * b) % m;
    end
    return r[rsa_w-1:0];
endfunction

// three cycle reset with the queues emptied while the DUT is held
task automatic restart();
    @(posedge avm_clk);
    avm_rst <= 1'b1;
    @(negedge avm_clk);
    in_q.delete();
    out_q.delete();
    repeat (3) @(posedge avm_clk);
    avm_rst <= 1'b0;
    @(negedge avm_clk);
endtask

task automatic queue_bytes(input logic [rsa_w-1:0] value);
    @(negedge avm_clk);
    for (int i = key_bytes - 1; i >= 0; i--) begin
        in_q.push_back(value[i*byte_w +: byte_w]);
    end
endtask

task automatic load_key(
    input logic [rsa_w-1:0] n,
    input logic [rsa_w-1:0] d,
    input logic [rsa_w-1:0] a
);
    restart();
    key_n  = n;
    key_d  = d;
    last_a = a;
    queue_bytes(n);
    queue_bytes(d);
    queue_bytes(a);
endtask

task automatic expect_block(input string name, input logic [rsa_w-1:0] expected);
    logic [rsa_w-1:0]  got;
    logic [data_w-1:0] word;
    got = '0;
    while (out_q.size() < out_bytes) begin
        @(negedge avm_clk);
    end
    for (int i = 0; i < out_bytes; i++) begin
        word = out_q.pop_front();
        check_value({name, " upper bits"}, '0, rsa_w'(word[data_w-1:byte_w]));
        got = {got[rsa_w-byte_w-1:0], word[byte_w-1:0]};
    end
    check_value(name, {8'h00, expected[rsa_w-byte_w-1:0]}, got);
    check_value({name, " unread input"}, '0, rsa_w'(in_q.size()));
    // with no ciphertext waiting the DUT must not write a 32nd byte
    repeat (quiet_cycles) @(negedge avm_clk);
    check_value({name, " extra bytes"}, '0, rsa_w'(out_q.size()));
endtask

task automatic test_reset_state();
    restart();
    check_value("reset_state write", '0, rsa_w'(avm_write));
    check_value("reset_state read", rsa_w'(1), rsa_w'(avm_read));
    check_value("reset_state address", rsa_w'(status_base), rsa_w'(avm_address));
    repeat (64) begin
        @(negedge avm_clk);
        check_value("reset_state idle write", '0, rsa_w'(avm_write));
    end
    check_value("reset_state output", '0, rsa_w'(out_q.size()));
endtask

task automatic test_small_key();
    load_key(rsa_w'(3233), rsa_w'(2753), rsa_w'(855));
    expect_block("small_key", mod_exp(last_a, key_d, key_n));
endtask

task automatic test_reuse_key();
    last_a = rsa_w'(65);
    queue_bytes(last_a);
    expect_block("reuse_key 1", mod_exp(last_a, key_d, key_n));
    last_a = rsa_w'(2790);
    queue_bytes(last_a);
    expect_block("reuse_key 2", mod_exp(last_a, key_d, key_n));
endtask

task automatic test_random_key();
    logic [rsa_w-1:0] n;
    logic [rsa_w-1:0] d;
    logic [rsa_w-1:0] a;
    // odd modulus with the top bit set
    n = pick_data(rsa_w) | {1'b1, {(rsa_w - 2){1'b0}}, 1'b1};
    d = pick_data(rsa_w);
    a = pick_data(rsa_w) % n;
    stall_en = 1'b1;
    load_key(n, d, a);
    expect_block("random_key", mod_exp(a, d, n));
endtask

task automatic test_gaps();
    gap_en = 1'b1;
    queue_bytes(last_a);
    expect_block("gaps", mod_exp(last_a, key_d, key_n));
endtask

task automatic test_edges();
    stall_en = 1'b0;
    gap_en   = 1'b0;
    load_key(rsa_w'(3233), rsa_w'(2753), '0);
    expect_block("edge_a0", '0);
    queue_bytes(rsa_w'(1));
    expect_block("edge_a1", rsa_w'(1));
    load_key(rsa_w'(3233), rsa_w'(1), rsa_w'(855));
    expect_block("edge_d1", rsa_w'(855));
endtask

// ==== verification/rsa_tb.sv ====
module rsa_tb
    import rsa_pkg::*;
();

    localparam int          clk_period   = 40;
    localparam logic [31:0] lfsr_seed    = 32'h67b5_4a12;
    // fixed core latency per block plus bus time for 96 reads and 31 writes
    localparam int          core_cycles  = 257 + 256 * 258 + 1;
    localparam int          total_blocks = 8;
    localparam int          byte_margin  = 64;
    // idle window after each block in which no further write may appear
    localparam int          quiet_cycles = 64;
    localparam int          limit_cycles =
        total_blocks * (core_cycles + 127 * byte_margin + quiet_cycles) + 2000;

    logic              avm_clk;
    logic              avm_rst = 1'b1;
    logic [addr_w-1:0] avm_address;
    logic              avm_read;
    logic [data_w-1:0] avm_readdata = '0;
    logic              avm_write;
    logic [data_w-1:0] avm_writedata;
    logic              avm_waitrequest = 1'b1;

    logic [byte_w-1:0] in_q[$];
    logic [data_w-1:0] out_q[$];
    logic [31:0]       stall_lfsr = lfsr_seed;
    logic [31:0]       data_lfsr = lfsr_seed;
    logic              stall_en = 1'b0;
    logic              gap_en = 1'b0;
    int                rx_gap;
    int                tx_busy;

    rsa_top i_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    initial begin
        avm_clk = 1'b0;
        forever begin
            #(clk_period / 2) avm_clk = ~avm_clk;
        end
    end

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(
        input string            name,
        input logic [rsa_w-1:0] expected,
        input logic [rsa_w-1:0] actual
    );
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int pick_stall(input int nbits);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            v = (v << 1) | int'(stall_lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [rsa_w-1:0] pick_data(input int nbits);
        logic [rsa_w-1:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            v = {v[rsa_w-2:0], data_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [data_w-1:0] reg_value(input logic [addr_w-1:0] addr);
        logic [data_w-1:0] v;
        v = '0;
        if (addr == rx_base && in_q.size() > 0) begin
            v[byte_w-1:0] = in_q[0];
        end else if (addr == status_base) begin
            v[rx_ok_bit] = (in_q.size() > 0) && (rx_gap == 0);
            v[tx_ok_bit] = (tx_busy == 0);
        end
        return v;
    endfunction

    // serial port slave model where a transfer takes two cycles at least
    always @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
            avm_readdata    <= '0;
            rx_gap  = 0;
            tx_busy = 0;
        end else begin
            if (rx_gap > 0) begin
                rx_gap = rx_gap - 1;
            end
            if (tx_busy > 0) begin
                tx_busy = tx_busy - 1;
            end
            if (!avm_waitrequest) begin
                // transfer completes on this edge
                avm_waitrequest <= 1'b1;
                if (avm_write && avm_address != tx_base) begin
                    $display("ERROR: write to address %0d instead of the tx register",
                             avm_address);
                    stop_run();
                end else if (avm_write && tx_busy != 0) begin
                    $display("ERROR: tx register written while the transmitter is busy");
                    stop_run();
                end else if (avm_read && avm_address == rx_base && in_q.size() == 0) begin
                    $display("ERROR: rx register read with no byte waiting");
                    stop_run();
                end else if (avm_write) begin
                    out_q.push_back(avm_writedata);
                    tx_busy = gap_en ? pick_stall(4) : 0;
                end else if (avm_address == rx_base) begin
                    void'(in_q.pop_front());
                    rx_gap = gap_en ? pick_stall(4) : 0;
                end
            end else if ((avm_read || avm_write) && !(stall_en && pick_stall(1) != 0)) begin
                avm_waitrequest <= 1'b0;
                avm_readdata    <= reg_value(avm_address);
            end
        end
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("ERROR: watchdog expired after %0d cycles, the DUT stopped making progress",
                 limit_cycles);
        stop_run();
    end

    `include "rsa_tb_tests.svh"

    initial begin
        test_reset_state();
        test_small_key();
        test_reuse_key();
        test_random_key();
        test_gaps();
        test_edges();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
design/rsa_pkg.sv
design/rsa_modprod.sv
design/rsa_mont.sv
design/rsa_core.sv
design/rsa_avm_wrapper.sv
design/rsa_top.sv
verification/rsa_tb.sv

// ==== Bender.yml ====
package:
  name: rsa_avm

sources:
  - files:
      - design/rsa_pkg.sv
      - design/rsa_modprod.sv
      - design/rsa_mont.sv
      - design/rsa_core.sv
      - design/rsa_avm_wrapper.sv
      - design/rsa_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/rsa_tb.sv
